//--- include/bp_defines.svh
// ------------------------------------------------
// branch predictor configuration macros
// table geometry, update credits and address
// bit positions used to index the history banks
// ------------------------------------------------

`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// fetch and branch address width
`define BP_VLEN 32

// instruction slots per fetch block, one bank each
`define BP_SLOTS 2
`define BP_SLOT_BITS 1

// table geometry
`define BP_ENTRIES 64
`define BP_ROWS (`BP_ENTRIES / `BP_SLOTS)
`define BP_ROW_BITS 5

// update credits, equal to the queue depth
`define BP_CREDITS 4

// ------------------------------------------------
// address bit positions
// ------------------------------------------------
// bit 0 is never used with compressed instructions
`define BP_PC_OFFSET 1
`define BP_SLOT_LSB `BP_PC_OFFSET
`define BP_ROW_LSB (`BP_SLOT_LSB + `BP_SLOT_BITS)
`define BP_ROW_MSB (`BP_ROW_LSB + `BP_ROW_BITS - 1)

`endif

//--- rtl/bp_pred_pkg.sv
// ------------------------------------------------
// lookup-side types of the branch history table
// 2-bit saturating counter and slot vectors
// ------------------------------------------------

`default_nettype none

`include "bp_defines.svh"

package bp_pred_pkg;

  // counter states, high bit gives the prediction
  typedef enum logic [1:0] {
    SAT_STRONG_NT = 2'b00,
    SAT_WEAK_NT   = 2'b01,
    SAT_WEAK_T    = 2'b10,
    SAT_STRONG_T  = 2'b11
  } sat_cnt_t;

  // one bit per slot of a fetch block
  typedef logic [`BP_SLOTS-1:0] slot_mask_t;

  // slot number inside a fetch block
  typedef logic [`BP_SLOT_BITS-1:0] slot_idx_t;

endpackage

`default_nettype wire

//--- rtl/bp_upd_pkg.sv
// ------------------------------------------------
// update-side types of the branch predictor
// resolved branch opcodes and the queue state
// ------------------------------------------------

`default_nettype none

package bp_upd_pkg;

  // ------------------------------------------------
  // resolved branch opcodes from execute
  // ------------------------------------------------
  // taken and not taken also mark the entry valid
  typedef enum logic [1:0] {
    OP_TAKEN      = 2'd0,
    OP_NOT_TAKEN  = 2'd1,
    // drops the entry back to weakly taken
    OP_INVALIDATE = 2'd2
  } upd_op_e;

  // ------------------------------------------------
  // update queue flush sequencer
  // ------------------------------------------------
  typedef enum logic {
    UQ_RUN   = 1'b0,
    UQ_FLUSH = 1'b1
  } uq_state_e;

endpackage

`default_nettype wire

//--- rtl/bp_update_queue.sv
// ------------------------------------------------
// update queue for resolved branches
// credit based FIFO, one pop per cycle, routes
// each popped entry to the bank of its slot
// ------------------------------------------------

`default_nettype none

`include "bp_defines.svh"

module bp_update_queue
  import bp_upd_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   flush_i,
  input  wire logic                   debug_mode_i,
  input  wire logic                   upd_valid_i,
  input  wire upd_op_e                upd_op_i,
  input  wire logic [`BP_VLEN-1:0]    upd_pc_i,
  output logic                        upd_credit_o,
  output logic [`BP_SLOTS-1:0]        bank_we_o,
  output logic [`BP_ROW_BITS-1:0]     bank_row_o,
  output upd_op_e                     bank_op_o
);

  localparam int unsigned PTR_BITS = (`BP_CREDITS > 1) ? $clog2(`BP_CREDITS) : 1;
  localparam int unsigned CNT_BITS = $clog2(`BP_CREDITS + 1);
  // slot and row bits of the address are all we keep
  localparam int unsigned IDX_BITS = `BP_SLOT_BITS + `BP_ROW_BITS;

  upd_op_e             op_q  [`BP_CREDITS];
  logic [IDX_BITS-1:0] idx_q [`BP_CREDITS];

  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic [CNT_BITS-1:0] count_d;
  uq_state_e           state_q;
  uq_state_e           state_d;

  logic                push;
  logic                pop;
  logic                drop;
  logic [IDX_BITS-1:0] head_idx;

  function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(`BP_CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ------------------------------------------------
  // push and pop
  // ------------------------------------------------
  // the sender never exceeds its credits, so a push always has room
  assign push    = upd_valid_i;
  assign pop     = (count_q != '0);
  assign count_d = count_q + CNT_BITS'(push) - CNT_BITS'(pop);

  // every pop returns a credit, applied or not
  assign upd_credit_o = pop;

  // discard while flushing or in debug mode
  assign drop = flush_i || (state_q == UQ_FLUSH) || debug_mode_i;

  assign head_idx   = idx_q[rd_ptr_q];
  assign bank_row_o = head_idx[IDX_BITS-1:`BP_SLOT_BITS];
  assign bank_op_o  = op_q[rd_ptr_q];

  // one-hot bank select from the slot bits
  always_comb begin
    bank_we_o = '0;
    if (pop && !drop) begin
      bank_we_o[head_idx[`BP_SLOT_BITS-1:0]] = 1'b1;
    end
  end

  // ------------------------------------------------
  // flush sequencer
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      UQ_RUN: begin
        if (flush_i) begin
          state_d = UQ_FLUSH;
        end
      end
      UQ_FLUSH: begin
        // stay until everything queued so far is gone
        if (!flush_i && (count_d == '0)) begin
          state_d = UQ_RUN;
        end
      end
      default: state_d = UQ_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= UQ_RUN;
    end else begin
      count_q <= count_d;
      state_q <= state_d;
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]  <= upd_op_i;
      idx_q[wr_ptr_q] <= upd_pc_i[`BP_ROW_MSB:`BP_SLOT_LSB];
    end
  end

endmodule

`default_nettype wire

//--- rtl/bht_bank.sv
// ------------------------------------------------
// branch history bank for one fetch slot
// valid bit plus 2-bit saturating counter per row,
// combinational read, one update per cycle
// ------------------------------------------------

`default_nettype none

`include "bp_defines.svh"

module bht_bank
  import bp_pred_pkg::*;
  import bp_upd_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    flush_i,
  input  wire logic [`BP_ROW_BITS-1:0] rd_row_i,
  input  wire logic                    we_i,
  input  wire logic [`BP_ROW_BITS-1:0] wr_row_i,
  input  wire upd_op_e                 wr_op_i,
  output logic                         valid_o,
  output logic                         taken_o
);

  logic     valid_q [`BP_ROWS];
  sat_cnt_t cnt_q   [`BP_ROWS];

  sat_cnt_t cnt_cur;
  sat_cnt_t cnt_nxt;
  logic     valid_nxt;

  // ------------------------------------------------
  // lookup
  // ------------------------------------------------
  assign valid_o = valid_q[rd_row_i];
  // high counter bit means taken
  assign taken_o = cnt_q[rd_row_i][1];

  // ------------------------------------------------
  // counter update
  // ------------------------------------------------
  always_comb begin
    cnt_cur   = cnt_q[wr_row_i];
    cnt_nxt   = cnt_cur;
    valid_nxt = valid_q[wr_row_i];
    case (wr_op_i)
      OP_TAKEN: begin
        valid_nxt = 1'b1;
        // saturate at strongly taken
        if (cnt_cur != SAT_STRONG_T) begin
          cnt_nxt = sat_cnt_t'(cnt_cur + 2'd1);
        end
      end
      OP_NOT_TAKEN: begin
        valid_nxt = 1'b1;
        // saturate at strongly not taken
        if (cnt_cur != SAT_STRONG_NT) begin
          cnt_nxt = sat_cnt_t'(cnt_cur - 2'd1);
        end
      end
      OP_INVALIDATE: begin
        valid_nxt = 1'b0;
        cnt_nxt   = SAT_WEAK_T;
      end
      default: begin
        cnt_nxt   = cnt_cur;
        valid_nxt = valid_q[wr_row_i];
      end
    endcase
  end

  // ------------------------------------------------
  // table state
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < `BP_ROWS; r++) begin
        valid_q[r] <= 1'b0;
        cnt_q[r]   <= SAT_STRONG_NT;
      end
    end else if (flush_i) begin
      // evict everything, a write in the same cycle is lost
      for (int r = 0; r < `BP_ROWS; r++) begin
        valid_q[r] <= 1'b0;
        cnt_q[r]   <= SAT_WEAK_T;
      end
    end else if (we_i) begin
      valid_q[wr_row_i] <= valid_nxt;
      cnt_q[wr_row_i]   <= cnt_nxt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/bp_pred_select.sv
// ------------------------------------------------
// prediction select for one fetch block
// masks raw slot predictions and finds the first
// taken slot at or after the fetch start slot
// ------------------------------------------------

`default_nettype none

`include "bp_defines.svh"

module bp_pred_select
  import bp_pred_pkg::*;
(
  input  wire logic [`BP_VLEN-1:0]  vpc_i,
  input  wire logic [`BP_SLOTS-1:0] slot_valid_i,
  input  wire logic [`BP_SLOTS-1:0] slot_taken_i,
  output logic [`BP_SLOTS-1:0]      pred_valid_o,
  output logic [`BP_SLOTS-1:0]      pred_taken_o,
  output logic                      br_taken_o,
  output logic [`BP_SLOT_BITS-1:0]  br_slot_o
);

  slot_idx_t  start_slot;
  slot_mask_t hit;
  slot_mask_t from_start;

  // fetch may start in the middle of the block
  assign start_slot = vpc_i[`BP_SLOT_LSB +: `BP_SLOT_BITS];

  // an invalid entry never predicts taken
  assign hit = slot_valid_i & slot_taken_i;

  assign pred_valid_o = slot_valid_i;
  assign pred_taken_o = hit;

  // slots the fetch actually covers
  always_comb begin
    from_start = '0;
    for (int s = 0; s < `BP_SLOTS; s++) begin
      from_start[s] = (slot_idx_t'(s) >= start_slot);
    end
  end

  // ------------------------------------------------
  // first taken slot, lowest index wins
  // ------------------------------------------------
  always_comb begin
    br_taken_o = 1'b0;
    br_slot_o  = '0;
    for (int s = 0; s < `BP_SLOTS; s++) begin
      if (!br_taken_o && hit[s] && from_start[s]) begin
        br_taken_o = 1'b1;
        br_slot_o  = slot_idx_t'(s);
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/bp_top.sv
// ------------------------------------------------
// branch history predictor top level
// update queue, one history bank per slot and the
// first taken slot select
// ------------------------------------------------

`default_nettype none

`include "bp_defines.svh"

module bp_top
  import bp_upd_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  flush_i,
  input  wire logic                  debug_mode_i,
  input  wire logic [`BP_VLEN-1:0]   vpc_i,
  input  wire logic                  upd_valid_i,
  input  wire upd_op_e               upd_op_i,
  input  wire logic [`BP_VLEN-1:0]   upd_pc_i,
  output logic                       upd_credit_o,
  output logic [`BP_SLOTS-1:0]       pred_valid_o,
  output logic [`BP_SLOTS-1:0]       pred_taken_o,
  output logic                       br_taken_o,
  output logic [`BP_SLOT_BITS-1:0]   br_slot_o
);

  logic [`BP_SLOTS-1:0]    bank_we;
  logic [`BP_ROW_BITS-1:0] bank_row;
  upd_op_e                 bank_op;
  logic [`BP_ROW_BITS-1:0] rd_row;
  logic [`BP_SLOTS-1:0]    slot_valid;
  logic [`BP_SLOTS-1:0]    slot_taken;

  // every bank reads the same row
  assign rd_row = vpc_i[`BP_ROW_MSB:`BP_ROW_LSB];

  bp_update_queue i_update_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .upd_valid_i  (upd_valid_i),
    .upd_op_i     (upd_op_i),
    .upd_pc_i     (upd_pc_i),
    .upd_credit_o (upd_credit_o),
    .bank_we_o    (bank_we),
    .bank_row_o   (bank_row),
    .bank_op_o    (bank_op)
  );

  // ------------------------------------------------
  // one bank per slot
  // ------------------------------------------------
  for (genvar i = 0; i < `BP_SLOTS; i++) begin : gen_banks
    bht_bank i_bank (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .flush_i  (flush_i),
      .rd_row_i (rd_row),
      .we_i     (bank_we[i]),
      .wr_row_i (bank_row),
      .wr_op_i  (bank_op),
      .valid_o  (slot_valid[i]),
      .taken_o  (slot_taken[i])
    );
  end

  bp_pred_select i_pred_select (
    .vpc_i        (vpc_i),
    .slot_valid_i (slot_valid),
    .slot_taken_i (slot_taken),
    .pred_valid_o (pred_valid_o),
    .pred_taken_o (pred_taken_o),
    .br_taken_o   (br_taken_o),
    .br_slot_o    (br_slot_o)
  );

endmodule

`default_nettype wire

//--- dv/bp_clk_gen.sv
// ------------------------------------------------
// testbench clock and reset
// 20 unit clock period, reset low for 3 cycles
// ------------------------------------------------

`default_nettype none

module bp_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // release on a falling edge, away from the active clock edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/bp_chk.sv
// ------------------------------------------------
// protocol checks for the branch predictor top
// update credits and lookup output consistency
// ------------------------------------------------

`default_nettype none

`include "bp_defines.svh"

module bp_chk (
  input wire logic                     clk_i,
  input wire logic                     rst_ni,
  input wire logic                     upd_valid_i,
  input wire logic                     upd_credit_i,
  input wire logic [`BP_SLOTS-1:0]     pred_valid_i,
  input wire logic [`BP_SLOTS-1:0]     pred_taken_i,
  input wire logic                     br_taken_i,
  input wire logic [`BP_SLOT_BITS-1:0] br_slot_i
);

  // credits the sender still holds
  int credits_q;

  // assertion failures seen so far
  int fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= `BP_CREDITS;
    end else begin
      credits_q <= credits_q - int'(upd_valid_i) + int'(upd_credit_i);
    end
  end

  // ------------------------------------------------
  // credit protocol
  // ------------------------------------------------
  credit_available: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_valid_i |-> (credits_q > 0))
    else begin
      fail_count++;
      $error("update sent with no credit left");
    end

  credit_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_credit_i |-> (credits_q < `BP_CREDITS))
    else begin
      fail_count++;
      $error("credit returned with none outstanding");
    end

  credit_quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !upd_credit_i)
    else begin
      fail_count++;
      $error("credit pulse during reset");
    end

  // ------------------------------------------------
  // lookup outputs
  // ------------------------------------------------
  taken_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pred_taken_i & ~pred_valid_i) == '0)
    else begin
      fail_count++;
      $error("taken slot without its valid bit");
    end

  branch_slot_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    br_taken_i |-> pred_taken_i[br_slot_i])
    else begin
      fail_count++;
      $error("first taken slot does not predict taken");
    end

endmodule

`default_nettype wire

//--- dv/bp_tb.sv
// ------------------------------------------------
// branch history predictor testbench
// credit sender, reference counter table and
// lookup checks against the reference
// ------------------------------------------------

`default_nettype none

`include "bp_defines.svh"

module bp_tb
  import bp_upd_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  logic                     debug_mode;
  logic [`BP_VLEN-1:0]      vpc;
  logic                     upd_valid;
  upd_op_e                  upd_op;
  logic [`BP_VLEN-1:0]      upd_pc;
  logic                     upd_credit;
  logic [`BP_SLOTS-1:0]     pred_valid;
  logic [`BP_SLOTS-1:0]     pred_taken;
  logic                     br_taken;
  logic [`BP_SLOT_BITS-1:0] br_slot;

  // reference table, counters kept as 0 to 3
  logic ref_valid [`BP_SLOTS][`BP_ROWS];
  int   ref_cnt   [`BP_SLOTS][`BP_ROWS];

  upd_op_e train_seq [12] = '{OP_TAKEN, OP_TAKEN, OP_TAKEN, OP_TAKEN,
                              OP_NOT_TAKEN, OP_NOT_TAKEN, OP_NOT_TAKEN,
                              OP_NOT_TAKEN, OP_NOT_TAKEN, OP_INVALIDATE,
                              OP_NOT_TAKEN, OP_TAKEN};

  int sent     = 0;
  int returned = 0;
  int errors   = 0;
  int timeouts = 0;

  bp_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  bp_top i_bp_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .flush_i      (flush),
    .debug_mode_i (debug_mode),
    .vpc_i        (vpc),
    .upd_valid_i  (upd_valid),
    .upd_op_i     (upd_op),
    .upd_pc_i     (upd_pc),
    .upd_credit_o (upd_credit),
    .pred_valid_o (pred_valid),
    .pred_taken_o (pred_taken),
    .br_taken_o   (br_taken),
    .br_slot_o    (br_slot)
  );

  bind bp_top bp_chk i_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .upd_valid_i  (upd_valid_i),
    .upd_credit_i (upd_credit_o),
    .pred_valid_i (pred_valid_o),
    .pred_taken_i (pred_taken_o),
    .br_taken_i   (br_taken_o),
    .br_slot_i    (br_slot_o)
  );

  // a credit seen at one falling edge is usable from the next one
  always @(negedge clk) begin
    if (upd_credit) begin
      returned <= returned + 1;
    end
  end

  // ------------------------------------------------
  // reference model
  // ------------------------------------------------
  function automatic void apply_ref(input upd_op_e op, input int slot, input int row);
    case (op)
      OP_TAKEN: begin
        ref_valid[slot][row] = 1'b1;
        if (ref_cnt[slot][row] < 3) begin
          ref_cnt[slot][row]++;
        end
      end
      OP_NOT_TAKEN: begin
        ref_valid[slot][row] = 1'b1;
        if (ref_cnt[slot][row] > 0) begin
          ref_cnt[slot][row]--;
        end
      end
      default: begin
        ref_valid[slot][row] = 1'b0;
        ref_cnt[slot][row]   = 2;
      end
    endcase
  endfunction

  function automatic void clear_ref(input int cnt);
    for (int s = 0; s < `BP_SLOTS; s++) begin
      for (int r = 0; r < `BP_ROWS; r++) begin
        ref_valid[s][r] = 1'b0;
        ref_cnt[s][r]   = cnt;
      end
    end
  endfunction

  function automatic upd_op_e random_op();
    int unsigned pick;
    pick = $urandom_range(0, 9);
    if (pick < 5) begin
      return OP_TAKEN;
    end
    if (pick < 9) begin
      return OP_NOT_TAKEN;
    end
    return OP_INVALIDATE;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      errors++;
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // ------------------------------------------------
  // sender and lookup
  // ------------------------------------------------
  task automatic send_update(input upd_op_e op, input int slot, input int row);
    int                  wait_cycles;
    logic [`BP_VLEN-1:0] pc;
    wait_cycles = 0;
    while (`BP_CREDITS - sent + returned == 0) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT) begin
        timeouts++;
        $display("timeout waiting for an update credit at %0t", $time);
        return;
      end
    end
    pc = $urandom();
    pc[`BP_ROW_MSB:`BP_ROW_LSB] = `BP_ROW_BITS'(row);
    pc[`BP_SLOT_LSB +: `BP_SLOT_BITS] = `BP_SLOT_BITS'(slot);
    upd_valid = 1'b1;
    upd_op    = op;
    upd_pc    = pc;
    sent++;
    if (!debug_mode) begin
      apply_ref(op, slot, row);
    end
    @(negedge clk);
    upd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int wait_cycles;
    wait_cycles = 0;
    while (returned != sent) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT) begin
        timeouts++;
        $display("timeout waiting for queued updates to drain at %0t", $time);
        break;
      end
    end
  endtask

  task automatic check_lookup(input int slot, input int row);
    logic [`BP_SLOTS-1:0]     exp_valid;
    logic [`BP_SLOTS-1:0]     exp_taken;
    logic                     exp_br;
    logic [`BP_SLOT_BITS-1:0] exp_slot;
    vpc = $urandom();
    vpc[`BP_ROW_MSB:`BP_ROW_LSB] = `BP_ROW_BITS'(row);
    vpc[`BP_SLOT_LSB +: `BP_SLOT_BITS] = `BP_SLOT_BITS'(slot);
    exp_br   = 1'b0;
    exp_slot = '0;
    for (int s = 0; s < `BP_SLOTS; s++) begin
      exp_valid[s] = ref_valid[s][row];
      exp_taken[s] = ref_valid[s][row] && (ref_cnt[s][row] >= 2);
    end
    for (int s = slot; s < `BP_SLOTS; s++) begin
      if (!exp_br && exp_taken[s]) begin
        exp_br   = 1'b1;
        exp_slot = `BP_SLOT_BITS'(s);
      end
    end
    // lookup is combinational, sample at the next falling edge
    @(negedge clk);
    expect_eq("pred_valid_o", 32'(exp_valid), 32'(pred_valid));
    expect_eq("pred_taken_o", 32'(exp_taken), 32'(pred_taken));
    expect_eq("br_taken_o", 32'(exp_br), 32'(br_taken));
    expect_eq("br_slot_o", 32'(exp_slot), 32'(br_slot));
  endtask

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------
  initial begin
    int wait_cycles;
    void'($urandom(29));
    flush      = 1'b0;
    debug_mode = 1'b0;
    vpc        = '0;
    upd_valid  = 1'b0;
    upd_op     = OP_TAKEN;
    upd_pc     = '0;
    clear_ref(0);

    wait_cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT) begin
        timeouts++;
        $display("timeout waiting for reset release");
        break;
      end
    end
    @(negedge clk);

    // empty table after reset
    for (int r = 0; r < `BP_ROWS; r++) begin
      check_lookup(r % `BP_SLOTS, r);
    end

    // saturating training, one entry per bank
    for (int s = 0; s < `BP_SLOTS; s++) begin
      for (int i = 0; i < 12; i++) begin
        send_update(train_seq[i], s, 5 + s);
        wait_drain();
        check_lookup(i % `BP_SLOTS, 5 + s);
      end
    end

    // first taken slot, each burst uses every credit
    for (int p = 0; p < 4; p++) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        send_update(p[s] ? OP_TAKEN : OP_NOT_TAKEN, s, 9);
        send_update(p[s] ? OP_TAKEN : OP_NOT_TAKEN, s, 9);
      end
      wait_drain();
      check_lookup(0, 9);
      check_lookup(1, 9);
    end
    send_update(OP_INVALIDATE, 0, 9);
    wait_drain();
    check_lookup(0, 9);
    check_lookup(1, 9);

    // debug mode drops updates but returns credits
    debug_mode = 1'b1;
    for (int i = 0; i < 6; i++) begin
      send_update(random_op(), $urandom_range(0, `BP_SLOTS - 1), 9);
    end
    wait_drain();
    debug_mode = 1'b0;
    check_lookup(0, 9);
    check_lookup(1, 9);

    // random traffic over a few rows
    for (int i = 0; i < 80; i++) begin
      send_update(random_op(), $urandom_range(0, `BP_SLOTS - 1), $urandom_range(0, 3));
      repeat ($urandom_range(0, 2)) @(negedge clk);
    end
    wait_drain();
    for (int r = 0; r < 4; r++) begin
      check_lookup(0, r);
      check_lookup(1, r);
    end

    // flush with an update in flight and one sent in the flush cycle
    for (int i = 0; i < 3; i++) begin
      send_update(OP_TAKEN, i % `BP_SLOTS, 12);
    end
    flush = 1'b1;
    send_update(OP_TAKEN, 0, 12);
    flush = 1'b0;
    clear_ref(2);
    wait_drain();
    for (int r = 0; r < `BP_ROWS; r++) begin
      check_lookup(r % `BP_SLOTS, r);
    end
    send_update(OP_NOT_TAKEN, 1, 12);
    wait_drain();
    check_lookup(0, 12);
    send_update(OP_TAKEN, 1, 12);
    wait_drain();
    check_lookup(1, 12);

    $display("errors %0d, assertion failures %0d, timeouts %0d", errors,
             i_bp_top.i_chk.fail_count, timeouts);
    if (errors == 0 && timeouts == 0 && i_bp_top.i_chk.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
rtl/bp_pred_pkg.sv
rtl/bp_upd_pkg.sv
rtl/bp_update_queue.sv
rtl/bht_bank.sv
rtl/bp_pred_select.sv
rtl/bp_top.sv
dv/bp_clk_gen.sv
dv/bp_chk.sv
dv/bp_tb.sv

//--- run.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module bp_tb -o bp_tb_sim

out=$(./obj_dir/bp_tb_sim)
echo "$out"
echo "$out" | grep -q "Test completed successfully"
